//--- byte_intake.sv
`timescale 1ns/1ps
`default_nettype none

module byte_intake (
    input  wire        clk,
    input  wire        reset,
    input  wire        wb_cyc,
    input  wire        wb_stb,
    input  wire        wb_we,
    input  wire  [7:0] wb_dat,
    output logic       wb_ack,
    byte_stage_if.source raw
);

    // one-entry buffer
    logic       full;
    logic [7:0] buf_data;
    logic       capture;

    // write strobe taken when the buffer is free or draining this cycle
    // the ack cycle itself never captures, one write per bus cycle
    assign capture = wb_cyc && wb_stb && wb_we && !wb_ack && (!full || raw.ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            full   <= 1'b0;
            wb_ack <= 1'b0;
        end else begin
            // registered ack, single cycle after capture
            wb_ack <= capture;
            if (capture) begin
                full <= 1'b1;
            end else if (raw.ready) begin
                // buffered byte moved downstream
                full <= 1'b0;
            end
        end
    end

    // payload only, no reset needed
    always_ff @(posedge clk) begin
        if (capture) begin
            buf_data <= wb_dat;
        end
    end

    // valid follows the buffer flag
    assign raw.valid = full;
    assign raw.data  = buf_data;

    // not classified yet
    assign raw.is_rep    = 1'b0;
    assign raw.seg_match = '0;
    assign raw.is_opsize = 1'b0;

endmodule

`default_nettype wire

//--- byte_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_stage_if import x86_prefix_pkg::*; ();

    // handshake
    logic valid;
    logic ready;

    // raw instruction byte
    logic [7:0] data;

    // classification, low on the raw link
    logic is_rep;
    logic [seg_onehot_w-1:0] seg_match;
    logic is_opsize;

    // producer side
    modport source (
        output valid,
        output data,
        output is_rep,
        output seg_match,
        output is_opsize,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  is_rep,
        input  seg_match,
        input  is_opsize,
        output ready
    );

endinterface

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none

package decode_pkg;

    // accumulator states
    // collect absorbs prefixes, emit holds a record for the consumer
    typedef enum logic [1:0] {
        st_collect,
        st_emit
    } accum_state_e;

    // prefix count field width
    localparam int count_w = 4;

    // count saturates here, longer prefix runs still report 15
    localparam logic [count_w-1:0] count_max = 4'd15;

endpackage

`default_nettype wire

//--- prefix_accum.sv
`timescale 1ns/1ps
`default_nettype none

module prefix_accum import x86_prefix_pkg::*, decode_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                out_ready,
    byte_stage_if.sink         cls,
    output logic               out_valid,
    output logic               out_rep,
    output seg_e               out_seg,
    output logic               out_opsize,
    output logic [count_w-1:0] out_count,
    output logic [7:0]         out_opcode
);

    accum_state_e       state;

    // prefixes seen so far for the current instruction
    logic               rep_acc;
    logic               opsize_acc;
    seg_e               seg_acc;
    logic [count_w-1:0] cnt_acc;

    logic               take;
    logic               is_prefix;

    // one-hot match to encoded segment
    function automatic seg_e onehot_to_seg(input logic [seg_onehot_w-1:0] m);
        seg_e s;
        s = seg_none;
        if (m[0]) s = seg_cs;
        else if (m[1]) s = seg_ss;
        else if (m[2]) s = seg_ds;
        else if (m[3]) s = seg_es;
        else if (m[4]) s = seg_fs;
        else if (m[5]) s = seg_gs;
        return s;
    endfunction

    // held record blocks input until the consumer takes it
    assign cls.ready = (state == st_collect) || out_ready;
    assign take      = cls.valid && cls.ready;
    assign is_prefix = cls.is_rep || cls.is_opsize || (|cls.seg_match);
    assign out_valid = (state == st_emit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_collect;
            rep_acc    <= 1'b0;
            opsize_acc <= 1'b0;
            seg_acc    <= seg_none;
            cnt_acc    <= '0;
        end else begin
            // record handed off
            if (out_valid && out_ready) begin
                state <= st_collect;
            end
            if (take) begin
                if (is_prefix) begin
                    // sticky flags
                    if (cls.is_rep) rep_acc <= 1'b1;
                    if (cls.is_opsize) opsize_acc <= 1'b1;
                    // last segment override wins
                    if (|cls.seg_match) seg_acc <= onehot_to_seg(cls.seg_match);
                    // saturating count
                    if (cnt_acc != count_max) cnt_acc <= cnt_acc + count_w'(1);
                end else begin
                    // opcode byte ends the instruction
                    state      <= st_emit;
                    rep_acc    <= 1'b0;
                    opsize_acc <= 1'b0;
                    seg_acc    <= seg_none;
                    cnt_acc    <= '0;
                end
            end
        end
    end

    // record payload, loaded on the opcode byte
    always_ff @(posedge clk) begin
        if (take && !is_prefix) begin
            out_rep    <= rep_acc;
            out_seg    <= seg_acc;
            out_opsize <= opsize_acc;
            out_count  <= cnt_acc;
            out_opcode <= cls.data;
        end
    end

endmodule

`default_nettype wire

//--- prefix_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module prefix_cmp import x86_prefix_pkg::*; (
    input wire clk,
    input wire reset,
    byte_stage_if.sink   raw,
    byte_stage_if.source cls
);

    // equality matches against the known codes, all in parallel
    logic                    rep_hit;
    logic [seg_onehot_w-1:0] seg_hit;
    logic                    opsize_hit;

    // output register
    logic                    valid_q;
    logic [7:0]              data_q;
    logic                    rep_q;
    logic [seg_onehot_w-1:0] seg_q;
    logic                    opsize_q;
    logic                    take;

    always_comb begin
        rep_hit    = (raw.data == prefix_rep);
        // bit order cs ss ds es fs gs
        seg_hit[0] = (raw.data == prefix_seg_cs);
        seg_hit[1] = (raw.data == prefix_seg_ss);
        seg_hit[2] = (raw.data == prefix_seg_ds);
        seg_hit[3] = (raw.data == prefix_seg_es);
        seg_hit[4] = (raw.data == prefix_seg_fs);
        seg_hit[5] = (raw.data == prefix_seg_gs);
        opsize_hit = (raw.data == prefix_opsize);
    end

    // accept when empty or being drained
    assign raw.ready = !valid_q || cls.ready;
    assign take      = raw.valid && raw.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (cls.ready) begin
            valid_q <= 1'b0;
        end
    end

    // byte and its match flags
    always_ff @(posedge clk) begin
        if (take) begin
            data_q   <= raw.data;
            rep_q    <= rep_hit;
            seg_q    <= seg_hit;
            opsize_q <= opsize_hit;
        end
    end

    assign cls.valid     = valid_q;
    assign cls.data      = data_q;
    assign cls.is_rep    = rep_q;
    assign cls.seg_match = seg_q;
    assign cls.is_opsize = opsize_q;

endmodule

`default_nettype wire

//--- prefix_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module prefix_decode_top import x86_prefix_pkg::*, decode_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    // wishbone classic slave, write only
    input  wire                wb_cyc,
    input  wire                wb_stb,
    input  wire                wb_we,
    input  wire  [7:0]         wb_dat,
    output logic               wb_ack,
    // decoded prefix record
    output logic               out_valid,
    input  wire                out_ready,
    output logic               out_rep,
    output seg_e               out_seg,
    output logic               out_opsize,
    output logic [count_w-1:0] out_count,
    output logic [7:0]         out_opcode
);

    // intake to comparator
    byte_stage_if s_raw ();
    // comparator to accumulator
    byte_stage_if s_cls ();

    // bus write buffer
    byte_intake byte_intake_i (
        .clk    (clk),
        .reset  (reset),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack),
        .raw    (s_raw.source)
    );

    // registered prefix match
    prefix_cmp prefix_cmp_i (
        .clk   (clk),
        .reset (reset),
        .raw   (s_raw.sink),
        .cls   (s_cls.source)
    );

    // record builder
    prefix_accum prefix_accum_i (
        .clk        (clk),
        .reset      (reset),
        .out_ready  (out_ready),
        .cls        (s_cls.sink),
        .out_valid  (out_valid),
        .out_rep    (out_rep),
        .out_seg    (out_seg),
        .out_opsize (out_opsize),
        .out_count  (out_count),
        .out_opcode (out_opcode)
    );

endmodule

`default_nettype wire

//--- project.f
x86_prefix_pkg.sv
decode_pkg.sv
byte_stage_if.sv
byte_intake.sv
prefix_cmp.sv
prefix_accum.sv
prefix_decode_top.sv
tb_prefix_decode_assert.sv
tb_prefix_decode.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_prefix_decode \
    -f project.f > build.log 2>&1 &&
./obj_dir/Vtb_prefix_decode > sim.log 2>&1
grep -q "^TEST PASSED$" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_prefix_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prefix_decode import x86_prefix_pkg::*, decode_pkg::*; ();

    // one decoded record
    typedef struct packed {
        logic               rep;
        seg_e               seg;
        logic               opsize;
        logic [count_w-1:0] count;
        logic [7:0]         opcode;
    } rec_t;

    // hand-written instruction, first byte in the top bits
    typedef struct packed {
        logic [47:0]        bytes;
        logic [2:0]         len;
        logic               rep;
        seg_e               seg;
        logic               opsize;
        logic [count_w-1:0] count;
        logic [7:0]         opcode;
    } row_t;

    localparam int n_rows   = 15;
    localparam int n_random = 40;

    localparam row_t rows [n_rows] = '{
        '{48'h90_00_00_00_00_00, 3'd1, 1'b0, seg_none, 1'b0, 4'd0, 8'h90},
        '{48'h2E_8B_00_00_00_00, 3'd2, 1'b0, seg_cs,   1'b0, 4'd1, 8'h8B},
        '{48'h36_8B_00_00_00_00, 3'd2, 1'b0, seg_ss,   1'b0, 4'd1, 8'h8B},
        '{48'h3E_8B_00_00_00_00, 3'd2, 1'b0, seg_ds,   1'b0, 4'd1, 8'h8B},
        '{48'h26_8B_00_00_00_00, 3'd2, 1'b0, seg_es,   1'b0, 4'd1, 8'h8B},
        '{48'h64_8B_00_00_00_00, 3'd2, 1'b0, seg_fs,   1'b0, 4'd1, 8'h8B},
        '{48'h65_8B_00_00_00_00, 3'd2, 1'b0, seg_gs,   1'b0, 4'd1, 8'h8B},
        '{48'h2E_65_89_00_00_00, 3'd3, 1'b0, seg_gs,   1'b0, 4'd2, 8'h89},
        '{48'hF3_A4_00_00_00_00, 3'd2, 1'b1, seg_none, 1'b0, 4'd1, 8'hA4},
        '{48'h66_F3_26_A5_00_00, 3'd4, 1'b1, seg_es,   1'b1, 4'd3, 8'hA5},
        '{48'h26_66_F3_AB_00_00, 3'd4, 1'b1, seg_es,   1'b1, 4'd3, 8'hAB},
        '{48'hF0_00_00_00_00_00, 3'd1, 1'b0, seg_none, 1'b0, 4'd0, 8'hF0},
        '{48'hF3_F2_00_00_00_00, 3'd2, 1'b1, seg_none, 1'b0, 4'd1, 8'hF2},
        '{48'h66_66_3E_2E_F3_C3, 3'd6, 1'b1, seg_cs,   1'b1, 4'd5, 8'hC3},
        '{48'h64_F0_00_00_00_00, 3'd2, 1'b0, seg_fs,   1'b0, 4'd1, 8'hF0}
    };

    logic clk, reset, wb_cyc, wb_stb, wb_we, wb_ack;
    logic [7:0] wb_dat;
    logic out_valid, out_ready, out_rep, out_opsize;
    seg_e out_seg;
    logic [count_w-1:0] out_count;
    logic [7:0] out_opcode;

    // byte stream, opcode markers, expected records in order
    logic [7:0] stim_bytes [$];
    bit         stim_last [$];
    rec_t       exp_q [$];
    int errors, rec_count, n_directed, n_total, limit_cycles;

    prefix_decode_top prefix_decode_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit is_prefix_code(input logic [7:0] b);
        return b inside {prefix_rep, prefix_opsize, prefix_seg_cs, prefix_seg_ss,
                         prefix_seg_ds, prefix_seg_es, prefix_seg_fs, prefix_seg_gs};
    endfunction

    function automatic seg_e segment_of(input logic [7:0] b);
        case (b)
            prefix_seg_cs: return seg_cs;
            prefix_seg_ss: return seg_ss;
            prefix_seg_ds: return seg_ds;
            prefix_seg_es: return seg_es;
            prefix_seg_fs: return seg_fs;
            prefix_seg_gs: return seg_gs;
            default:       return seg_none;
        endcase
    endfunction

    // reference model step for one prefix byte
    function automatic rec_t apply_prefix(input rec_t r, input logic [7:0] b);
        rec_t n;
        n = r;
        if (b == prefix_rep) n.rep = 1'b1;
        else if (b == prefix_opsize) n.opsize = 1'b1;
        else n.seg = segment_of(b);
        // saturating count
        if (n.count != count_max) n.count = n.count + 1'b1;
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // classic write, held through the edge that samples ack
    task automatic wb_write(input logic [7:0] b);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = b;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        // ack completes the cycle on the coming rising edge
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // intake, comparator and accumulator registers, ack rises with the first
    // write returns one cycle after ack was seen
    task automatic check_latency();
        int n;
        n = 1;
        while (!out_valid && n < 8) begin
            @(negedge clk);
            n++;
        end
        check_value("out_valid latency", n, 2);
    endtask

    initial begin
        rec_t r;
        logic [31:0] st;
        int n_pre;
        int instr;
        logic [7:0] b;
        logic [7:0] codes [8];
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_dat = 8'h00;
        codes = '{prefix_rep, prefix_opsize, prefix_seg_cs, prefix_seg_ss,
                  prefix_seg_ds, prefix_seg_es, prefix_seg_fs, prefix_seg_gs};
        // directed rows
        for (int i = 0; i < n_rows; i++) begin
            for (int k = 0; k < rows[i].len; k++) begin
                stim_bytes.push_back(rows[i].bytes[47-8*k -: 8]);
                stim_last.push_back(k == rows[i].len - 1);
            end
            exp_q.push_back(rec_t'{rows[i].rep, rows[i].seg, rows[i].opsize,
                                   rows[i].count, rows[i].opcode});
        end
        // 18 prefixes, count stops at 15
        for (int k = 0; k < 18; k++) begin
            stim_bytes.push_back(k < 16 ? prefix_seg_ds : (k == 16 ? prefix_rep : prefix_opsize));
            stim_last.push_back(1'b0);
        end
        stim_bytes.push_back(8'h0F);
        stim_last.push_back(1'b1);
        exp_q.push_back(rec_t'{1'b1, seg_ds, 1'b1, 4'd15, 8'h0F});
        n_directed = n_rows + 1;
        // random instructions
        st = 32'd96339;
        for (int i = 0; i < n_random; i++) begin
            r = '0;
            st = lcg_next(st);
            n_pre = int'((st >> 16) % 19);
            for (int k = 0; k < n_pre; k++) begin
                st = lcg_next(st);
                b = codes[(st >> 16) % 8];
                stim_bytes.push_back(b);
                stim_last.push_back(1'b0);
                r = apply_prefix(r, b);
            end
            st = lcg_next(st);
            b = st[23:16];
            // flip the top bit to leave the prefix codes
            if (is_prefix_code(b)) b = b ^ 8'h80;
            r.opcode = b;
            stim_bytes.push_back(b);
            stim_last.push_back(1'b1);
            exp_q.push_back(r);
        end
        n_total = exp_q.size();
        limit_cycles = 40 * stim_bytes.size() + 200;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        instr = 0;
        for (int i = 0; i < stim_bytes.size(); i++) begin
            wb_write(stim_bytes[i]);
            if (stim_last[i]) begin
                if (instr < n_directed) check_latency();
                instr++;
            end
        end
        wait (rec_count == n_total);
        repeat (4) @(negedge clk);
        $display("summary: %0d errors, %0d of %0d records received", errors, rec_count, n_total);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // record collector, random back-pressure once the directed records are out
    initial begin
        logic [31:0] st;
        int hold;
        rec_t e;
        st = 32'd96339;
        hold = 0;
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (rec_count < n_directed) begin
                out_ready = 1'b1;
            end else begin
                if (hold == 0) begin
                    st = lcg_next(st);
                    hold = 1 + int'((st >> 16) % 6);
                    out_ready = st[24];
                end
                hold--;
            end
            // transfer happens on the coming rising edge
            if (!reset && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("extra record at %0t with opcode 0x%0h", $time, out_opcode);
                end else begin
                    e = exp_q.pop_front();
                    check_value("out_rep", out_rep, e.rep);
                    check_value("out_seg", out_seg, e.seg);
                    check_value("out_opsize", out_opsize, e.opsize);
                    check_value("out_count", out_count, e.count);
                    check_value("out_opcode", out_opcode, e.opcode);
                end
                rec_count++;
            end
        end
    end

    // watchdog sized from the byte count
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped responding", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_prefix_decode_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prefix_decode_assert import x86_prefix_pkg::*, decode_pkg::*; (
    input wire                clk,
    input wire                reset,
    input wire                wb_cyc,
    input wire                wb_stb,
    input wire                wb_ack,
    input wire                out_valid,
    input wire                out_ready,
    input wire                out_rep,
    input seg_e               out_seg,
    input wire                out_opsize,
    input wire [count_w-1:0]  out_count,
    input wire [7:0]          out_opcode,
    input accum_state_e       accum_state,
    input wire                raw_valid,
    input wire                cls_valid
);

    // single-cycle ack
    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack high two cycles in a row");

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside an active bus cycle");

    // record held while the consumer stalls
    hold_record: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_rep) && $stable(out_seg)
            && $stable(out_opsize) && $stable(out_count) && $stable(out_opcode)))
        else $error("record changed while stalled");

    valid_after_reset: assert property (@(posedge clk) $past(reset) |-> !out_valid)
        else $error("out_valid high right after reset");

    // all three stages full and stalled, no new write accepted
    no_ack_when_full: assert property (@(posedge clk) disable iff (reset)
        (raw_valid && cls_valid && out_valid && !out_ready) |=> !wb_ack)
        else $error("wb_ack while the pipeline is full");

    // handed-off record with no new opcode behind it returns to collect
    state_release: assert property (@(posedge clk) disable iff (reset)
        (accum_state == st_emit && out_ready && !cls_valid) |=> (accum_state == st_collect))
        else $error("accumulator stayed in emit after the record was taken");

endmodule

bind prefix_decode_top tb_prefix_decode_assert tb_prefix_decode_assert_i (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_rep     (out_rep),
    .out_seg     (out_seg),
    .out_opsize  (out_opsize),
    .out_count   (out_count),
    .out_opcode  (out_opcode),
    .accum_state (prefix_accum_i.state),
    .raw_valid   (s_raw.valid),
    .cls_valid   (s_cls.valid)
);

`default_nettype wire

//--- x86_prefix_pkg.sv
`default_nettype none

package x86_prefix_pkg;

    // rep prefix, only F3 is decoded here
    localparam logic [7:0] prefix_rep = 8'hF3;

    // segment override prefixes
    localparam logic [7:0] prefix_seg_cs = 8'h2E;
    localparam logic [7:0] prefix_seg_ss = 8'h36;
    localparam logic [7:0] prefix_seg_ds = 8'h3E;
    localparam logic [7:0] prefix_seg_es = 8'h26;
    localparam logic [7:0] prefix_seg_fs = 8'h64;
    localparam logic [7:0] prefix_seg_gs = 8'h65;

    // operand-size override
    localparam logic [7:0] prefix_opsize = 8'h66;

    // one-hot segment match vector
    // bit 0 cs, 1 ss, 2 ds, 3 es, 4 fs, 5 gs
    localparam int seg_onehot_w = 6;

    // encoded segment override carried in the record
    // seg_none when no segment prefix was seen
    typedef enum logic [2:0] {
        seg_none,
        seg_cs,
        seg_ss,
        seg_ds,
        seg_es,
        seg_fs,
        seg_gs
    } seg_e;

endpackage

`default_nettype wire
